// File: rtl/fp_adder.sv
// Fixed latency of four cycles with no back-pressure; one operation may enter every cycle
module fp_adder
(
	input  logic                                         clk,
	input  logic                                         reset,
	input  logic                                         valid,
	input  fp_op_pkg::fp_opcode_t                        opcode,
	input  logic [fp_format_pkg::total_width-1:0]        operand_a,
	input  logic [fp_format_pkg::total_width-1:0]        operand_b,
	output logic                                         result_valid,
	output logic [fp_format_pkg::total_width-1:0]        result
);

	// Stage 1 to stage 2
	logic                                         add1_valid;
	logic [fp_format_pkg::exponent_width-1:0]     add1_exponent;
	logic [fp_format_pkg::shift_width-1:0]        add1_shift;
	logic [fp_format_pkg::significand_width:0]    add1_significand_large;
	logic [fp_format_pkg::significand_width:0]    add1_significand_small;
	logic                                         add1_sign_large;
	logic                                         add1_sign_small;

	// Stage 2 to stage 3
	logic                                         add2_valid;
	logic [fp_format_pkg::exponent_width-1:0]     add2_exponent;
	logic [fp_format_pkg::internal_width-1:0]     add2_significand1;
	logic [fp_format_pkg::internal_width-1:0]     add2_significand2;

	// Stage 3 to stage 4
	logic                                         add3_valid;
	logic [fp_format_pkg::internal_width-1:0]     add3_significand;
	logic                                         add3_sign;
	logic [fp_format_pkg::exponent_width-1:0]     add3_exponent;

	// Compare exponents and order operands
	fp_adder_stage1 stage1_i
	(
		.clk                    (clk),
		.reset                  (reset),
		.valid                  (valid),
		.opcode                 (opcode),
		.operand_a              (operand_a),
		.operand_b              (operand_b),
		.add1_valid             (add1_valid),
		.add1_exponent          (add1_exponent),
		.add1_shift             (add1_shift),
		.add1_significand_large (add1_significand_large),
		.add1_significand_small (add1_significand_small),
		.add1_sign_large        (add1_sign_large),
		.add1_sign_small        (add1_sign_small)
	);

	// Align and apply signs
	fp_adder_stage2 stage2_i
	(
		.clk                    (clk),
		.reset                  (reset),
		.add1_valid             (add1_valid),
		.add1_exponent          (add1_exponent),
		.add1_shift             (add1_shift),
		.add1_significand_large (add1_significand_large),
		.add1_significand_small (add1_significand_small),
		.add1_sign_large        (add1_sign_large),
		.add1_sign_small        (add1_sign_small),
		.add2_valid             (add2_valid),
		.add2_exponent          (add2_exponent),
		.add2_significand1      (add2_significand1),
		.add2_significand2      (add2_significand2)
	);

	// Add
	fp_adder_stage3 stage3_i
	(
		.clk                    (clk),
		.reset                  (reset),
		.add2_valid             (add2_valid),
		.add2_significand1      (add2_significand1),
		.add2_significand2      (add2_significand2),
		.add2_exponent          (add2_exponent),
		.add3_valid             (add3_valid),
		.add3_significand       (add3_significand),
		.add3_sign              (add3_sign),
		.add3_exponent          (add3_exponent)
	);

	// Normalize and pack
	fp_adder_stage4 stage4_i
	(
		.clk                    (clk),
		.reset                  (reset),
		.add3_valid             (add3_valid),
		.add3_significand       (add3_significand),
		.add3_sign              (add3_sign),
		.add3_exponent          (add3_exponent),
		.result_valid           (result_valid),
		.result                 (result)
	);

endmodule

// File: rtl/fp_adder_stage1.sv
// Denormal inputs are read as zero; NaN and infinity are handled as ordinary numbers
module fp_adder_stage1
(
	input  logic                                         clk,
	input  logic                                         reset,
	input  logic                                         valid,
	input  fp_op_pkg::fp_opcode_t                        opcode,
	input  logic [fp_format_pkg::total_width-1:0]        operand_a,
	input  logic [fp_format_pkg::total_width-1:0]        operand_b,
	output logic                                         add1_valid,
	output logic [fp_format_pkg::exponent_width-1:0]     add1_exponent,
	output logic [fp_format_pkg::shift_width-1:0]        add1_shift,
	output logic [fp_format_pkg::significand_width:0]    add1_significand_large,
	output logic [fp_format_pkg::significand_width:0]    add1_significand_small,
	output logic                                         add1_sign_large,
	output logic                                         add1_sign_small
);

	// Unpacked fields of both operands
	logic                                         sign_a;
	logic                                         sign_b;
	logic [fp_format_pkg::exponent_width-1:0]     exponent_a;
	logic [fp_format_pkg::exponent_width-1:0]     exponent_b;
	logic [fp_format_pkg::significand_width:0]    significand_a;
	logic [fp_format_pkg::significand_width:0]    significand_b;

	// Ordered operands before the register
	logic                                         a_is_large;
	logic [fp_format_pkg::exponent_width-1:0]     exponent_large;
	logic [fp_format_pkg::exponent_width-1:0]     exponent_small;
	logic [fp_format_pkg::exponent_width-1:0]     exponent_diff;
	logic [fp_format_pkg::shift_width-1:0]        shift_nxt;

	// Sign of b follows the opcode
	assign sign_a = operand_a[fp_format_pkg::total_width-1];
	assign sign_b = operand_b[fp_format_pkg::total_width-1] ^ (opcode == fp_op_pkg::op_sub);

	assign exponent_a = operand_a[fp_format_pkg::total_width-2:fp_format_pkg::significand_width];
	assign exponent_b = operand_b[fp_format_pkg::total_width-2:fp_format_pkg::significand_width];

	// Hidden bit restored for normal numbers
	// A zero exponent means zero or denormal, both become zero
	assign significand_a = (exponent_a != '0)
		? {1'b1, operand_a[fp_format_pkg::significand_width-1:0]} : '0;
	assign significand_b = (exponent_b != '0)
		? {1'b1, operand_b[fp_format_pkg::significand_width-1:0]} : '0;

	// Larger exponent wins, ties go to the larger significand
	assign a_is_large = (exponent_a > exponent_b)
		|| ((exponent_a == exponent_b) && (significand_a >= significand_b));

	assign exponent_large = a_is_large ? exponent_a : exponent_b;
	assign exponent_small = a_is_large ? exponent_b : exponent_a;
	assign exponent_diff = exponent_large - exponent_small;

	// Clamp the alignment shift
	always_comb
	begin
		if (int'(exponent_diff) > fp_format_pkg::max_shift)
			shift_nxt = fp_format_pkg::max_shift[fp_format_pkg::shift_width-1:0];
		else
			shift_nxt = exponent_diff[fp_format_pkg::shift_width-1:0];
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			add1_valid <= 1'b0;
			add1_exponent <= '0;
			add1_shift <= '0;
			add1_significand_large <= '0;
			add1_significand_small <= '0;
			add1_sign_large <= 1'b0;
			add1_sign_small <= 1'b0;
		end
		else
		begin
			add1_valid <= valid;
			add1_exponent <= exponent_large;
			add1_shift <= shift_nxt;
			// Data moves every cycle, valid alone marks it
			add1_significand_large <= a_is_large ? significand_a : significand_b;
			add1_significand_small <= a_is_large ? significand_b : significand_a;
			add1_sign_large <= a_is_large ? sign_a : sign_b;
			add1_sign_small <= a_is_large ? sign_b : sign_a;
		end
	end

endmodule

// File: rtl/fp_adder_stage2.sv
// Bits shifted out of the small operand are dropped, so the sum is truncated and has no sticky bit
module fp_adder_stage2
(
	input  logic                                         clk,
	input  logic                                         reset,
	input  logic                                         add1_valid,
	input  logic [fp_format_pkg::exponent_width-1:0]     add1_exponent,
	input  logic [fp_format_pkg::shift_width-1:0]        add1_shift,
	input  logic [fp_format_pkg::significand_width:0]    add1_significand_large,
	input  logic [fp_format_pkg::significand_width:0]    add1_significand_small,
	input  logic                                         add1_sign_large,
	input  logic                                         add1_sign_small,
	output logic                                         add2_valid,
	output logic [fp_format_pkg::exponent_width-1:0]     add2_exponent,
	output logic [fp_format_pkg::internal_width-1:0]     add2_significand1,
	output logic [fp_format_pkg::internal_width-1:0]     add2_significand2
);

	// Small operand after alignment
	logic [fp_format_pkg::significand_width:0]    aligned_small;

	// Both operands widened with room for sign and carry
	logic [fp_format_pkg::internal_width-1:0]     wide_large;
	logic [fp_format_pkg::internal_width-1:0]     wide_small;

	// Two's complement forms
	logic [fp_format_pkg::internal_width-1:0]     signed_large;
	logic [fp_format_pkg::internal_width-1:0]     signed_small;

	// A shift of max_shift empties the operand
	assign aligned_small = add1_significand_small >> add1_shift;

	// Two zero bits on top: sign slot and carry slot
	assign wide_large = {2'b00, add1_significand_large};
	assign wide_small = {2'b00, aligned_small};

	// Negate where the sign is set
	always_comb
	begin
		if (add1_sign_large)
			signed_large = ~wide_large + 1'b1;
		else
			signed_large = wide_large;

		if (add1_sign_small)
			signed_small = ~wide_small + 1'b1;
		else
			signed_small = wide_small;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			add2_valid <= 1'b0;
			add2_exponent <= '0;
			add2_significand1 <= '0;
			add2_significand2 <= '0;
		end
		else
		begin
			add2_valid <= add1_valid;
			// Exponent of the large operand carries through
			add2_exponent <= add1_exponent;
			add2_significand1 <= signed_large;
			add2_significand2 <= signed_small;
		end
	end

endmodule

// File: rtl/fp_adder_stage3.sv
// The sum never reaches the sign bit by overflow since both inputs are below two to the 25th
module fp_adder_stage3
(
	input  logic                                         clk,
	input  logic                                         reset,
	input  logic                                         add2_valid,
	input  logic [fp_format_pkg::internal_width-1:0]     add2_significand1,
	input  logic [fp_format_pkg::internal_width-1:0]     add2_significand2,
	input  logic [fp_format_pkg::exponent_width-1:0]     add2_exponent,
	output logic                                         add3_valid,
	output logic [fp_format_pkg::internal_width-1:0]     add3_significand,
	output logic                                         add3_sign,
	output logic [fp_format_pkg::exponent_width-1:0]     add3_exponent
);

	// Two's complement sum
	logic [fp_format_pkg::internal_width-1:0]     sum;

	// Sign and magnitude of the sum
	logic [fp_format_pkg::internal_width-1:0]     magnitude_nxt;
	logic                                         sign_nxt;

	assign sum = add2_significand1 + add2_significand2;

	// Back to sign and magnitude
	always_comb
	begin
		if (sum[fp_format_pkg::internal_width-1])
		begin
			magnitude_nxt = ~sum + 1'b1;
			sign_nxt = 1'b1;
		end
		else
		begin
			magnitude_nxt = sum;
			sign_nxt = 1'b0;
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			add3_valid <= 1'b0;
			add3_significand <= '0;
			add3_sign <= 1'b0;
			add3_exponent <= '0;
		end
		else
		begin
			add3_valid <= add2_valid;
			add3_significand <= magnitude_nxt;
			add3_sign <= sign_nxt;
			add3_exponent <= add2_exponent;
		end
	end

endmodule

// File: rtl/fp_adder_stage4.sv
// Truncates toward zero, flushes underflow to +0 and does not detect exponent overflow
module fp_adder_stage4
(
	input  logic                                         clk,
	input  logic                                         reset,
	input  logic                                         add3_valid,
	input  logic [fp_format_pkg::internal_width-1:0]     add3_significand,
	input  logic                                         add3_sign,
	input  logic [fp_format_pkg::exponent_width-1:0]     add3_exponent,
	output logic                                         result_valid,
	output logic [fp_format_pkg::total_width-1:0]        result
);

	// Leading zeros below the carry bit
	logic [fp_format_pkg::exponent_width-1:0]     lead_zeros;
	logic                                         found_one;

	// Magnitude shifted so the hidden bit is set
	logic [fp_format_pkg::significand_width:0]    normalized;

	// Fields of the packed result
	logic [fp_format_pkg::significand_width-1:0]  fraction_nxt;
	logic [fp_format_pkg::exponent_width-1:0]     exponent_nxt;
	logic [fp_format_pkg::total_width-1:0]        result_nxt;

	// Scan from the hidden bit down for the first one
	always_comb
	begin
		lead_zeros = '0;
		found_one = 1'b0;
		for (int i = fp_format_pkg::hidden_bit; i >= 0; i--)
		begin
			if (!found_one)
			begin
				if (add3_significand[i])
					found_one = 1'b1;
				else
					lead_zeros = lead_zeros + 1'b1;
			end
		end
	end

	assign normalized = add3_significand[fp_format_pkg::hidden_bit:0] << lead_zeros;

	always_comb
	begin
		if (add3_significand[fp_format_pkg::carry_bit])
		begin
			// Carry out of a same-sign add
			// One place right, exponent up by one, lowest bit truncated
			fraction_nxt = add3_significand[fp_format_pkg::significand_width:1];
			exponent_nxt = add3_exponent + 1'b1;
			result_nxt = {add3_sign, exponent_nxt, fraction_nxt};
		end
		else
		begin
			// Left shift by the zero count
			fraction_nxt = normalized[fp_format_pkg::significand_width-1:0];
			exponent_nxt = add3_exponent - lead_zeros;

			// Zero magnitude or exponent at or below zero gives +0
			if (!found_one || (add3_exponent <= lead_zeros))
				result_nxt = '0;
			else
				result_nxt = {add3_sign, exponent_nxt, fraction_nxt};
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			result_valid <= 1'b0;
			result <= '0;
		end
		else
		begin
			result_valid <= add3_valid;
			result <= result_nxt;
		end
	end

endmodule

// File: rtl/fp_format_pkg.sv
// Single precision layout only; widths are tied together and are not meant to be changed alone
package fp_format_pkg;

	// Exponent field of the packed word
	localparam int exponent_width = 8;

	// Stored fraction, hidden bit not included
	localparam int significand_width = 23;

	// Sign, exponent and fraction packed together
	localparam int total_width = 1 + exponent_width + significand_width;

	// Exponent bias of the format
	localparam int exponent_bias = 127;

	// Aligned significand in stages 2 and 3
	// Sign bit, carry bit, hidden bit, then the fraction
	localparam int internal_width = significand_width + 3;

	// Any larger alignment shift leaves nothing of the small operand
	localparam int max_shift = internal_width;

	// Bits needed to hold a shift of 0 up to max_shift
	localparam int shift_width = $clog2(max_shift + 1);

	// Bit positions inside the aligned significand
	// hidden_bit is the leading one of a normal number
	// carry_bit catches the overflow of a same-sign add
	localparam int hidden_bit = significand_width;
	localparam int carry_bit = significand_width + 1;

endpackage

// File: rtl/fp_op_pkg.sv
// Only add and subtract exist; the opcode is sampled together with the operands
package fp_op_pkg;

	// Operation applied to operand_a and operand_b
	// op_sub flips the sign of operand_b before the add
	typedef enum logic
	{
		op_add = 1'b0,
		op_sub = 1'b1
	} fp_opcode_t;

	// Cycles from an accepted input to its result
	// One register per stage, four stages
	localparam int pipeline_latency = 4;

endpackage

// File: run.sh
#!/bin/sh
# Compiles the fp_adder testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

log_file=sim.log
sim_name=fp_adder_sim

verilator --binary --timing -Wno-fatal -f src.f --top-module fp_adder_tb -o "$sim_name"
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator compile failed with status $status"
	exit 1
fi

./obj_dir/"$sim_name" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Errors found" "$log_file"; then
	echo "FAIL: see $log_file"
	exit 1
fi

if ! grep -q "No errors" "$log_file"; then
	echo "FAIL: simulation ended without a result line"
	exit 1
fi

echo "PASS"
exit 0

// File: src.f
+incdir+include
rtl/fp_format_pkg.sv
rtl/fp_op_pkg.sv
rtl/fp_adder_stage1.sv
rtl/fp_adder_stage2.sv
rtl/fp_adder_stage3.sv
rtl/fp_adder_stage4.sv
rtl/fp_adder.sv
testbench/fp_adder_tb.sv

// File: include/fp_adder_vectors.svh
// Words are IEEE single precision; expected values assume truncation and flush of denormals to +0
`ifndef fp_adder_vectors_svh
`define fp_adder_vectors_svh

// Columns: opcode (0 add, 1 sub), operand_a, operand_b, expected result
localparam int vector_count = 18;

localparam logic [fp_format_pkg::total_width-1:0] vector_table [vector_count][4] = '{
	// 1.0 + 2.0 = 3.0
	'{32'h0, 32'h3F80_0000, 32'h4000_0000, 32'h4040_0000},
	// 1.5 + 0.25 = 1.75
	'{32'h0, 32'h3FC0_0000, 32'h3E80_0000, 32'h3FE0_0000},
	// 1.5 + 1.5 = 3.0, carry and exponent up
	'{32'h0, 32'h3FC0_0000, 32'h3FC0_0000, 32'h4040_0000},
	// 1.5 + 1.75 = 3.25
	'{32'h0, 32'h3FC0_0000, 32'h3FE0_0000, 32'h4050_0000},
	// Carry drops the lowest bit, truncated to 2.0
	'{32'h0, 32'h3F80_0001, 32'h3F80_0000, 32'h4000_0000},
	// 1.0 - 3.0 = -2.0, b is the larger one
	'{32'h1, 32'h3F80_0000, 32'h4040_0000, 32'hC000_0000},
	// -2.5 + 1.0 = -1.5
	'{32'h0, 32'hC020_0000, 32'h3F80_0000, 32'hBFC0_0000},
	// -1.0 - 1.0 = -2.0
	'{32'h1, 32'hBF80_0000, 32'h3F80_0000, 32'hC000_0000},
	// 1.0 - (-1.0) = 2.0
	'{32'h1, 32'h3F80_0000, 32'hBF80_0000, 32'h4000_0000},
	// 1.0 - 0.9990234375 = 2^-10, ten places of left shift
	'{32'h1, 32'h3F80_0000, 32'h3F7F_C000, 32'h3A80_0000},
	// 3.0 - 3.0 = +0
	'{32'h1, 32'h4040_0000, 32'h4040_0000, 32'h0000_0000},
	// -1.5 + 1.5 = +0
	'{32'h0, 32'hBFC0_0000, 32'h3FC0_0000, 32'h0000_0000},
	// 1.0e10 + 1.0, small operand shifted out completely
	'{32'h0, 32'h5015_02F9, 32'h3F80_0000, 32'h5015_02F9},
	// 1.0 + 2^-24 stays 1.0
	'{32'h0, 32'h3F80_0000, 32'h3380_0000, 32'h3F80_0000},
	// 0 + 1.75
	'{32'h0, 32'h0000_0000, 32'h3FE0_0000, 32'h3FE0_0000},
	// Denormal reads as zero
	'{32'h0, 32'h0000_0001, 32'h4000_0000, 32'h4000_0000},
	// Difference of two tiny normals underflows to +0
	'{32'h1, 32'h0080_0001, 32'h0080_0000, 32'h0000_0000},
	// Two denormals give +0 even with a negative one
	'{32'h0, 32'h807F_FFFF, 32'h0000_0003, 32'h0000_0000}
};

`endif

// File: testbench/fp_adder_tb.sv
// Hand-derived expected words only; pipeline latency taken from fp_op_pkg, no rounding modes covered
module fp_adder_tb;

	// Vector table lives in the module scope
	`include "fp_adder_vectors.svh"

	localparam int reset_cycles = 8;
	// Row before which the stream pauses
	localparam int idle_row = 9;
	localparam int idle_cycles = 4;
	// Quiet cycles after the last result to catch stray strobes
	localparam int tail_cycles = fp_op_pkg::pipeline_latency + 2;
	// Reset, one idle, all rows, the gap, the drain, the tail and a margin
	localparam int timeout_limit = reset_cycles + 1 + vector_count + idle_cycles
		+ fp_op_pkg::pipeline_latency + tail_cycles + 20;

	logic                                     clk;
	logic                                     reset;
	logic                                     valid;
	fp_op_pkg::fp_opcode_t                    opcode;
	logic [fp_format_pkg::total_width-1:0]    operand_a;
	logic [fp_format_pkg::total_width-1:0]    operand_b;
	logic                                     result_valid;
	logic [fp_format_pkg::total_width-1:0]    result;

	// Operations in flight, oldest first
	logic [fp_format_pkg::total_width-1:0]    expected_q[$];
	logic [fp_format_pkg::total_width-1:0]    operand_a_q[$];
	logic [fp_format_pkg::total_width-1:0]    operand_b_q[$];
	logic                                     opcode_q[$];
	int                                       input_cycle_q[$];

	// Entry popped for the result being checked
	logic [fp_format_pkg::total_width-1:0]    expected_word;
	logic [fp_format_pkg::total_width-1:0]    sent_a;
	logic [fp_format_pkg::total_width-1:0]    sent_b;
	logic                                     sent_op;
	int                                       input_cycle;

	// Posedges seen so far
	int                                       cycle_count;
	int                                       result_count;
	int                                       error_count;

	fp_adder dut_i
	(
		.clk          (clk),
		.reset        (reset),
		.valid        (valid),
		.opcode       (opcode),
		.operand_a    (operand_a),
		.operand_b    (operand_b),
		.result_valid (result_valid),
		.result       (result)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;
	end

	// Puts one row on the inputs and queues what must come out
	task automatic apply_row(input int row);
		@(posedge clk);
		valid <= 1'b1;
		opcode <= fp_op_pkg::fp_opcode_t'(vector_table[row][0][0]);
		operand_a <= vector_table[row][1];
		operand_b <= vector_table[row][2];
		opcode_q.push_back(vector_table[row][0][0]);
		operand_a_q.push_back(vector_table[row][1]);
		operand_b_q.push_back(vector_table[row][2]);
		expected_q.push_back(vector_table[row][3]);
	endtask

	// A cycle where nothing enters, data lines get junk
	task automatic idle_cycle();
		@(posedge clk);
		valid <= 1'b0;
		operand_a <= 32'h4049_0FDB;
		operand_b <= 32'hC2F6_E979;
	endtask

	// Cycle counter and the run limit
	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == timeout_limit)
		begin
			$display("Timeout at cycle %0d, results stopped arriving with %0d still pending",
				cycle_count, expected_q.size());
			$display("Rows %0d, results %0d, errors %0d",
				vector_count, result_count, error_count);
			$display("Errors found");
			$finish;
		end
	end

	// Outputs are read at the falling edge, half a cycle after they settle
	always @(negedge clk)
	begin
		if (reset)
		begin
			if (result_valid)
			begin
				$display("result_valid was high during reset at time %0t", $time);
				error_count++;
			end
		end
		else
		begin
			// Cycle in which this input sits on the pins
			if (valid)
				input_cycle_q.push_back(cycle_count);
			if (result_valid)
			begin
				if (expected_q.size() == 0)
				begin
					$display("result_valid went high at time %0t with no operation pending",
						$time);
					error_count++;
				end
				else
				begin
					expected_word = expected_q.pop_front();
					sent_a = operand_a_q.pop_front();
					sent_b = operand_b_q.pop_front();
					sent_op = opcode_q.pop_front();
					input_cycle = input_cycle_q.pop_front();
					result_count++;
					if (result !== expected_word)
					begin
						$display("error at time %0t: op %0d a %h b %h expected %h got %h",
							$time, sent_op, sent_a, sent_b, expected_word, result);
						error_count++;
					end
					if (cycle_count - input_cycle != fp_op_pkg::pipeline_latency)
					begin
						$display("error at time %0t: result after %0d cycles, expected %0d",
							$time, cycle_count - input_cycle, fp_op_pkg::pipeline_latency);
						error_count++;
					end
				end
			end
		end
	end

	initial
	begin
		reset = 1'b1;
		valid = 1'b0;
		opcode = fp_op_pkg::op_add;
		operand_a = '0;
		operand_b = '0;
		repeat (reset_cycles)
			@(posedge clk);
		reset <= 1'b0;
		idle_cycle();

		// Back to back rows with one pause in the middle
		for (int row = 0; row < vector_count; row++)
		begin
			if (row == idle_row)
				repeat (idle_cycles)
					idle_cycle();
			apply_row(row);
		end
		idle_cycle();

		// Drain, the cycle counter stops a hang
		while (expected_q.size() != 0)
			@(posedge clk);
		repeat (tail_cycles)
			@(posedge clk);

		if (result_count != vector_count)
		begin
			$display("Only %0d results came out for %0d rows", result_count, vector_count);
			error_count++;
		end
		$display("Rows %0d, results %0d, errors %0d", vector_count, result_count, error_count);
		if (error_count == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule
